//--- Bender.yml
package:
  name: dac_interp

sources:
  - files:
      - rtl/dac_interp_pkg.sv
      - rtl/fir_interp.sv
      - rtl/cic_interp.sv
      - rtl/dac_interp_filter.sv
      - rtl/dac_interp_top.sv
  - target: test
    files:
      - testbench/dac_interp_tb.sv

//--- rtl/cic_interp.sv
// ************************************************************
// Two-stage CIC interpolator
// Combs at the input rate, integrators at the strobe rate
// Runtime rate select and 1/R gain correction
// ************************************************************

`timescale 1ns/1ps

module cic_interp #(
  parameter int DATA_W = 16
) (
  input  logic                       dac_clk,
  input  logic                       rst_n,
  input  logic                       clr,
  input  logic                       ce,
  input  dac_interp_pkg::filt_mode_e mode,
  input  dac_interp_pkg::sample_t    din,
  output dac_interp_pkg::sample_t    dout,
  output logic                       req
);

  // 48 bits hold a full-scale input times R up to 50000 with margin
  localparam int ACC_W = 48;
  localparam int GAIN_W = 16;
  localparam int PROD_W = ACC_W + GAIN_W + 1;
  localparam logic signed [PROD_W-1:0] HALF_LSB = PROD_W'(2 ** (GAIN_W - 1));
  localparam logic signed [PROD_W-1:0] SAT_MAX = PROD_W'(2 ** (DATA_W - 1) - 1);
  localparam logic signed [PROD_W-1:0] SAT_MIN = -SAT_MAX - PROD_W'(1);

  logic [15:0]              rate;
  logic [15:0]              cnt;
  // High on the enable that takes a new input sample
  logic                     wrap;
  logic signed [ACC_W-1:0]  x_in;
  logic signed [ACC_W-1:0]  comb1;
  logic signed [ACC_W-1:0]  comb2;
  logic signed [ACC_W-1:0]  comb1_d;
  logic signed [ACC_W-1:0]  comb2_d;
  logic signed [ACC_W-1:0]  integ1;
  logic signed [ACC_W-1:0]  integ2;
  logic signed [PROD_W-1:0] prod;

  // Drop the 16 fraction bits with rounding, then clip
  function automatic logic signed [DATA_W-1:0] round_sat(input logic signed [PROD_W-1:0] v);
    logic signed [PROD_W-1:0] r;
    r = (v + HALF_LSB) >>> GAIN_W;
    if (r > SAT_MAX) begin
      return SAT_MAX[DATA_W-1:0];
    end else if (r < SAT_MIN) begin
      return SAT_MIN[DATA_W-1:0];
    end
    return r[DATA_W-1:0];
  endfunction

  // ************************************************************
  // Rate counter and comb section
  // ************************************************************

  assign rate = dac_interp_pkg::cic_rate(mode);
  // The compare also recovers when the rate drops below the count
  assign wrap = ce && (cnt >= rate - 16'd1);

  // Nothing enters until the FIR has produced its first sample
  assign x_in  = din.valid ? ACC_W'(din.data) : '0;
  assign comb1 = x_in - comb1_d;
  assign comb2 = comb1 - comb2_d;

  // Integrator output scaled by 1/R in Q0.16
  assign prod = PROD_W'(integ2)
              * PROD_W'($signed({1'b0, dac_interp_pkg::cic_gain_q16(mode)}));

  always_ff @(posedge dac_clk) begin
    if (!rst_n || clr) begin
      cnt     <= '0;
      req     <= 1'b0;
      comb1_d <= '0;
      comb2_d <= '0;
      integ1  <= '0;
      integ2  <= '0;
      dout    <= '0;
    end else begin
      req        <= wrap;
      dout.valid <= ce;
      if (ce) begin
        cnt <= wrap ? '0 : cnt + 16'd1;
        // Zero stuffing lets the comb result in only once per R enables
        if (wrap) begin
          integ1 <= integ1 + comb2;
        end
        integ2    <= integ2 + integ1;
        dout.data <= round_sat(prod);
      end
      if (wrap) begin
        comb1_d <= x_in;
        comb2_d <= comb1;
      end
    end
  end

endmodule

//--- rtl/dac_interp_filter.sv
// ************************************************************
// Interpolation filter controller
// Mode decode, rate-change reset, request thinning
// Output selection between raw and filtered data
// ************************************************************

`timescale 1ns/1ps

module dac_interp_filter #(
  parameter int DATA_W  = 16,
  parameter int RATIO_W = 32
) (
  input  logic               dac_clk,
  input  logic               rst_n,
  input  logic [DATA_W-1:0]  dac_data,
  input  logic               dac_valid,
  input  logic [2:0]         filter_mask,
  input  logic [RATIO_W-1:0] interpolation_ratio,
  input  logic               dma_transfer_suspend,
  output logic [DATA_W-1:0]  dac_int_data,
  output logic               dac_int_valid
);

  logic [2:0]                 mask_d;
  // One-cycle pulse after every mask change
  logic                       filt_rst;
  // Clear for both filters that is also held while the DMA is suspended
  logic                       filt_clr;
  dac_interp_pkg::filt_mode_e mode;
  dac_interp_pkg::sample_t    fir_out;
  dac_interp_pkg::sample_t    cic_out;
  logic                       fir_req;
  logic                       cic_req;
  // Request before ratio thinning
  logic                       req_src;
  logic                       thin_en;
  logic [RATIO_W-1:0]         ratio_cnt;

  // ************************************************************
  // Filter chain
  // ************************************************************

  assign filt_clr = filt_rst || dma_transfer_suspend;

  // The FIR advances each time the CIC asks for a new sample
  fir_interp #(
    .DATA_W (DATA_W)
  ) u_fir (
    .dac_clk (dac_clk),
    .rst_n   (rst_n),
    .clr     (filt_clr),
    .ce      (cic_req),
    .din     (dac_data),
    .dout    (fir_out),
    .req     (fir_req)
  );

  // The CIC runs at the converter strobe rate
  cic_interp #(
    .DATA_W (DATA_W)
  ) u_cic (
    .dac_clk (dac_clk),
    .rst_n   (rst_n),
    .clr     (filt_clr),
    .ce      (dac_valid),
    .mode    (mode),
    .din     (fir_out),
    .dout    (cic_out),
    .req     (cic_req)
  );

  // ************************************************************
  // Mode register and change detect
  // ************************************************************

  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      mask_d   <= '0;
      filt_rst <= 1'b0;
      mode     <= dac_interp_pkg::bypass;
    end else begin
      mask_d   <= filter_mask;
      filt_rst <= (mask_d != filter_mask);
      mode     <= dac_interp_pkg::decode_mode(filter_mask);
    end
  end

  // In bypass every strobe asks for data unless the DMA is suspended
  assign req_src = (mode == dac_interp_pkg::bypass) ? (dac_valid && !dma_transfer_suspend)
                                                    : fir_req;
  // Ratios of 0 and 1 pass every request
  assign thin_en = (interpolation_ratio > RATIO_W'(1));

  // Pass one request in every ratio+1 as the one that finds the count at the ratio
  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      ratio_cnt     <= '0;
      dac_int_valid <= 1'b0;
    end else if (!thin_en) begin
      ratio_cnt     <= '0;
      dac_int_valid <= req_src;
    end else if (req_src) begin
      if (ratio_cnt < interpolation_ratio) begin
        ratio_cnt     <= ratio_cnt + RATIO_W'(1);
        dac_int_valid <= 1'b0;
      end else begin
        ratio_cnt     <= '0;
        dac_int_valid <= 1'b1;
      end
    end else begin
      dac_int_valid <= 1'b0;
    end
  end

  // Raw data goes straight through in bypass
  always_comb begin
    if (mode == dac_interp_pkg::bypass) begin
      dac_int_data = dac_data;
    end else begin
      dac_int_data = cic_out.data;
    end
  end

endmodule

//--- rtl/dac_interp_pkg.sv
// ************************************************************
// Shared definitions for the DAC interpolation subsystem
// Filter-mode enum and the mask decoder
// CIC rate table and its gain-correction table
// Halfband FIR coefficients and the sample struct
// ************************************************************

package dac_interp_pkg;

  // Decoded filter mode with one value per CIC rate plus bypass
  typedef enum logic [2:0] {
    bypass     = 3'd0,
    rate_5     = 3'd1,
    rate_50    = 3'd2,
    rate_500   = 3'd3,
    rate_5000  = 3'd4,
    rate_50000 = 3'd5
  } filt_mode_e;

  // One sample on its way through the chain
  typedef struct packed {
    logic signed [15:0] data;
    logic               valid;
  } sample_t;

  // ************************************************************
  // Halfband coefficients in Q4 indexed by distance from centre
  // ************************************************************

  localparam int FIR_TAPS = 7;
  localparam int FIR_FRAC = 4;
  // Centre tap is 0.5
  localparam logic signed [4:0] FIR_C0 = 5'sd8;
  // Taps next to the centre are 0.3125
  localparam logic signed [4:0] FIR_C1 = 5'sd5;
  // Even taps of a halfband are zero
  localparam logic signed [4:0] FIR_C2 = 5'sd0;
  // Outer taps are -0.0625
  localparam logic signed [4:0] FIR_C3 = -5'sd1;

  // Any nonzero mask filters and unknown codes fall back to the lowest rate
  function automatic filt_mode_e decode_mode(input logic [2:0] mask);
    case (mask)
      3'd0: return bypass;
      3'd1: return rate_5;
      3'd2: return rate_50;
      3'd3: return rate_500;
      3'd6: return rate_5000;
      3'd7: return rate_50000;
      default: return rate_5;
    endcase
  endfunction

  // CIC interpolation rate for each mode
  function automatic logic [15:0] cic_rate(input filt_mode_e mode);
    case (mode)
      rate_5:     return 16'd5;
      rate_50:    return 16'd50;
      rate_500:   return 16'd500;
      rate_5000:  return 16'd5000;
      rate_50000: return 16'd50000;
      default:    return 16'd1;
    endcase
  endfunction

  // Rounded 1/R in unsigned Q0.16 where unity saturates to the largest code
  function automatic logic [15:0] cic_gain_q16(input filt_mode_e mode);
    case (mode)
      rate_5:     return 16'd13107;
      rate_50:    return 16'd1311;
      rate_500:   return 16'd131;
      rate_5000:  return 16'd13;
      rate_50000: return 16'd1;
      default:    return 16'hffff;
    endcase
  endfunction

endpackage

//--- rtl/dac_interp_top.sv
// ************************************************************
// DAC interpolation subsystem top level
// Sets the widths and wires the filter controller to the pins
// ************************************************************

`timescale 1ns/1ps

module dac_interp_top #(
  parameter int DATA_W  = 16,
  parameter int RATIO_W = 32
) (
  input  logic               dac_clk,
  input  logic               rst_n,
  input  logic [DATA_W-1:0]  dac_data,
  input  logic               dac_valid,
  input  logic [2:0]         filter_mask,
  input  logic [RATIO_W-1:0] interpolation_ratio,
  input  logic               dma_transfer_suspend,
  output logic [DATA_W-1:0]  dac_int_data,
  output logic               dac_int_valid
);

  // A single channel needs one controller with its FIR and CIC
  dac_interp_filter #(
    .DATA_W  (DATA_W),
    .RATIO_W (RATIO_W)
  ) u_filter (
    .dac_clk              (dac_clk),
    .rst_n                (rst_n),
    .dac_data             (dac_data),
    .dac_valid            (dac_valid),
    .filter_mask          (filter_mask),
    .interpolation_ratio  (interpolation_ratio),
    .dma_transfer_suspend (dma_transfer_suspend),
    .dac_int_data         (dac_int_data),
    .dac_int_valid        (dac_int_valid)
  );

endmodule

//--- rtl/fir_interp.sv
// ************************************************************
// 2x polyphase halfband interpolating FIR
// Alternates centre-tap and odd-tap phases on each enable
// ************************************************************

`timescale 1ns/1ps

module fir_interp #(
  parameter int DATA_W = 16
) (
  input  logic                    dac_clk,
  input  logic                    rst_n,
  input  logic                    clr,
  input  logic                    ce,
  input  logic [DATA_W-1:0]       din,
  output dac_interp_pkg::sample_t dout,
  output logic                    req
);

  // Seven full-rate taps span four input samples
  localparam int HIST = (dac_interp_pkg::FIR_TAPS + 1) / 2;
  // Room for the coefficient sums plus sign
  localparam int ACC_W = DATA_W + 5;
  // One bit less than the coefficient fraction gives the 2x interpolation gain
  localparam int SHIFT = dac_interp_pkg::FIR_FRAC - 1;
  localparam logic signed [ACC_W-1:0] HALF_LSB = ACC_W'(2 ** (SHIFT - 1));
  localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(2 ** (DATA_W - 1) - 1);
  localparam logic signed [ACC_W-1:0] SAT_MIN = -SAT_MAX - ACC_W'(1);

  // Input history, entry 0 is the newest sample
  logic signed [DATA_W-1:0] hist [HIST];
  // Low selects the centre-tap phase, high the odd-tap phase
  logic                     phase;
  logic signed [ACC_W-1:0]  acc_centre;
  logic signed [ACC_W-1:0]  acc_odd;

  // Round to nearest, then clip to the sample range
  function automatic logic signed [DATA_W-1:0] round_sat(input logic signed [ACC_W-1:0] v);
    logic signed [ACC_W-1:0] r;
    r = (v + HALF_LSB) >>> SHIFT;
    if (r > SAT_MAX) begin
      return SAT_MAX[DATA_W-1:0];
    end else if (r < SAT_MIN) begin
      return SAT_MIN[DATA_W-1:0];
    end
    return r[DATA_W-1:0];
  endfunction

  // ************************************************************
  // Phase sums
  // ************************************************************

  always_comb begin
    // Centre phase lands on the sample that becomes entry 2 after the shift
    acc_centre = ACC_W'(hist[1]) * ACC_W'(dac_interp_pkg::FIR_C0)
               + (ACC_W'(hist[0]) + ACC_W'(hist[2])) * ACC_W'(dac_interp_pkg::FIR_C2);
    // Odd phase sits halfway between entries 1 and 2
    acc_odd = (ACC_W'(hist[1]) + ACC_W'(hist[2])) * ACC_W'(dac_interp_pkg::FIR_C1)
            + (ACC_W'(hist[0]) + ACC_W'(hist[3])) * ACC_W'(dac_interp_pkg::FIR_C3);
  end

  always_ff @(posedge dac_clk) begin
    if (!rst_n || clr) begin
      phase <= 1'b0;
      req   <= 1'b0;
      dout  <= '0;
      for (int i = 0; i < HIST; i++) begin
        hist[i] <= '0;
      end
    end else begin
      req <= 1'b0;
      if (ce) begin
        phase      <= ~phase;
        dout.valid <= 1'b1;
        if (!phase) begin
          // Consume a new input and tell the controller about it
          hist[0] <= din;
          for (int i = 1; i < HIST; i++) begin
            hist[i] <= hist[i-1];
          end
          req       <= 1'b1;
          dout.data <= round_sat(acc_centre);
        end else begin
          dout.data <= round_sat(acc_odd);
        end
      end
    end
  end

endmodule

//--- tb.f
rtl/dac_interp_pkg.sv
rtl/fir_interp.sv
rtl/cic_interp.sv
rtl/dac_interp_filter.sv
rtl/dac_interp_top.sv
testbench/dac_interp_tb.sv

//--- testbench/dac_interp_tb.sv
// ************************************************************
// Testbench for the DAC interpolation subsystem
// Stimulus table applied row by row, clock and reset
// Request counting, bypass data and settled output checks
// Watchdog sized from the table
// ************************************************************

`timescale 1ns/1ps

module dac_interp_tb;

  localparam int DATA_W = 16;
  localparam int RATIO_W = 32;
  localparam int MAX_ROWS = 16;
  localparam int CLK_NS = 8;
  localparam int RESET_CYCLES = 2;
  // Idle cycles after a mask change, and after the last strobe of a row
  localparam int SETTLE = 4;
  localparam int TAIL = 4;
  // Allowed distance of a settled filtered output from its target
  localparam int OUT_TOL = 4;

  // One row of the stimulus table
  typedef struct packed {
    logic [2:0]  mask;
    logic [31:0] ratio;
    logic        suspend;
    logic [15:0] value;
    logic [15:0] strobes;
    logic [7:0]  spacing;
    logic [15:0] exp_req;
    logic [7:0]  req_tol;
    logic        out_chk;
    logic [15:0] exp_out;
    logic [15:0] first_min;
    logic [15:0] first_max;
  } row_t;

  logic               dac_clk;
  logic               rst_n;
  logic [DATA_W-1:0]  dac_data;
  logic               dac_valid;
  logic [2:0]         filter_mask;
  logic [RATIO_W-1:0] interpolation_ratio;
  logic               dma_transfer_suspend;
  logic [DATA_W-1:0]  dac_int_data;
  logic               dac_int_valid;

  row_t   rows [MAX_ROWS];
  string  row_name [MAX_ROWS];
  int     num_rows;
  integer seed;
  string  cur_name;
  // Scoring state of the row being applied
  bit     counting;
  bit     data_chk;
  bit     seen_req;
  int     req_count;
  int     strobe_count;
  int     first_req;

  dac_interp_top #(
    .DATA_W  (DATA_W),
    .RATIO_W (RATIO_W)
  ) uut (
    .dac_clk              (dac_clk),
    .rst_n                (rst_n),
    .dac_data             (dac_data),
    .dac_valid            (dac_valid),
    .filter_mask          (filter_mask),
    .interpolation_ratio  (interpolation_ratio),
    .dma_transfer_suspend (dma_transfer_suspend),
    .dac_int_data         (dac_int_data),
    .dac_int_valid        (dac_int_valid)
  );

  initial begin
    dac_clk = 1'b0;
    forever #(CLK_NS / 2) dac_clk = ~dac_clk;
  end

  task automatic check_value(input string name, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: %s expected %0d actual %0d", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic add_row(input string name, input int mask, input int ratio, input int suspend,
                         input int value, input int strobes, input int spacing,
                         input int exp_req, input int req_tol, input int out_chk,
                         input int exp_out, input int first_min, input int first_max);
    row_t r;
    r.mask      = 3'(mask);
    r.ratio     = 32'(ratio);
    r.suspend   = 1'(suspend);
    r.value     = 16'(value);
    r.strobes   = 16'(strobes);
    r.spacing   = 8'(spacing);
    r.exp_req   = 16'(exp_req);
    r.req_tol   = 8'(req_tol);
    r.out_chk   = 1'(out_chk);
    r.exp_out   = 16'(exp_out);
    r.first_min = 16'(first_min);
    r.first_max = 16'(first_max);
    rows[num_rows]     = r;
    row_name[num_rows] = name;
    num_rows++;
  endtask

  // ************************************************************
  // Stimulus table
  // ************************************************************

  // Filtered request counts follow N/(2R), one FIR input per two CIC requests
  // The R = 50 row stops halfway through a CIC period so the next mask change has a count to clear
  task automatic load_table();
    num_rows = 0;
    //       name              mask ratio susp value strb  spc req tol ochk out  fmin fmax
    add_row("bypass_rand",     0,   0,    0,   0,    64,   2,  64, 0,  0,   0,    0,   0);
    add_row("ratio_3",         0,   3,    0,   0,    40,   2,  10, 0,  0,   0,    0,   0);
    add_row("ratio_1",         0,   1,    0,   0,    40,   2,  40, 0,  0,   0,    0,   0);
    add_row("bypass_suspend",  0,   0,    1,   0,    32,   2,  0,  0,  0,   0,    0,   0);
    add_row("dc_rate_5",       1,   0,    0,   8000, 200,  2,  20, 1,  1,   8000, 0,   0);
    add_row("dc_rate_50",      2,   0,    0,   8000, 1025, 2,  10, 1,  1,   8000, 0,   0);
    add_row("mask_change",     1,   0,    0,   8000, 10,   2,  1,  1,  0,   0,    5,   10);
    add_row("filt_suspend",    2,   0,    1,   8000, 50,   2,  0,  0,  1,   0,    0,   0);
    add_row("bypass_sparse",   0,   0,    0,   0,    24,   5,  24, 0,  0,   0,    0,   0);
  endtask

  // One clock cycle. Outputs are sampled at the falling edge, then new inputs are driven
  task automatic step(input logic strobe, input logic [DATA_W-1:0] data);
    @(negedge dac_clk);
    if (counting && dac_int_valid) begin
      req_count++;
      if (!seen_req) begin
        seen_req  = 1'b1;
        first_req = strobe_count;
      end
    end
    // In bypass the output follows the input without a register
    if (data_chk && dac_valid) begin
      check_value({cur_name, " bypass data"}, $signed(dac_data), $signed(dac_int_data));
    end
    dac_valid = strobe;
    dac_data  = data;
    if (strobe) begin
      strobe_count++;
    end
  endtask

  task automatic apply_row(input int idx);
    row_t              r;
    logic [DATA_W-1:0] d;
    integer            rnd;
    int                diff;
    int                lo;
    int                hi;
    r        = rows[idx];
    cur_name = row_name[idx];
    d        = r.value;
    // A mask change here pulses the filter reset inside the DUT
    counting             = 1'b0;
    data_chk             = 1'b0;
    filter_mask          = r.mask;
    interpolation_ratio  = r.ratio;
    dma_transfer_suspend = r.suspend;
    dac_valid            = 1'b0;
    dac_data             = d;
    repeat (SETTLE) step(1'b0, d);
    counting     = 1'b1;
    data_chk     = (r.mask == 3'd0);
    seen_req     = 1'b0;
    req_count    = 0;
    strobe_count = 0;
    first_req    = 0;
    for (int s = 0; s < int'(r.strobes); s++) begin
      for (int c = 0; c < int'(r.spacing); c++) begin
        // Bypass rows get fresh random data on each strobe
        if (r.mask == 3'd0 && c == 0) begin
          rnd = $random(seed);
          d   = rnd[DATA_W-1:0];
        end
        step(c == 0, d);
      end
    end
    repeat (TAIL) step(1'b0, d);
    counting = 1'b0;
    data_chk = 1'b0;
    // ************************************************************
    // Scoring of the row
    // ************************************************************
    if (r.req_tol == 8'd0) begin
      check_value({cur_name, " request count"}, int'(r.exp_req), req_count);
    end else begin
      lo = int'(r.exp_req) - int'(r.req_tol);
      hi = int'(r.exp_req) + int'(r.req_tol);
      check_value({cur_name, " request count in range"}, 1, (req_count >= lo && req_count <= hi));
    end
    if (r.out_chk) begin
      diff = int'($signed(dac_int_data)) - int'($signed(r.exp_out));
      if (diff < 0) begin
        diff = -diff;
      end
      check_value({cur_name, " settled output near target"}, 1, diff <= OUT_TOL);
    end
    // A cleared CIC counter holds the first request back until R strobes have passed
    if (r.first_max != 16'd0) begin
      check_value({cur_name, " first request in time"}, 1,
                  seen_req && (first_req >= int'(r.first_min))
                  && (first_req <= int'(r.first_max)));
    end
  endtask

  initial begin
    seed                 = 32'h6e70_7245;
    rst_n                = 1'b0;
    dac_data             = '0;
    dac_valid            = 1'b0;
    filter_mask          = 3'd0;
    interpolation_ratio  = '0;
    dma_transfer_suspend = 1'b0;
    counting             = 1'b0;
    data_chk             = 1'b0;
    load_table();
    repeat (RESET_CYCLES) @(negedge dac_clk);
    rst_n = 1'b1;
    step(1'b0, '0);
    check_value("reset valid low", 0, dac_int_valid);
    for (int i = 0; i < num_rows; i++) begin
      apply_row(i);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Watchdog sized from the table length plus a fifth
  initial begin : watchdog
    longint cycles;
    longint limit_ns;
    #1;
    cycles = RESET_CYCLES + 2;
    for (int i = 0; i < num_rows; i++) begin
      cycles += longint'(rows[i].strobes) * longint'(rows[i].spacing) + SETTLE + TAIL;
    end
    limit_ns = cycles * CLK_NS * 12 / 10;
    #(limit_ns);
    $display("Timeout: the table did not finish within %0d ns", limit_ns + 1);
    $display("*** TEST FAILED ***");
    $fatal(1, "Watchdog expired");
  end

endmodule
